//--- verilog/c64_audio_consts.svh
// C64 audio block constants
// Tick ring length, sample clamp limits, cassette click level and the
// number of mix channels shared by the audio RTL and its testbench
`ifndef C64_AUDIO_CONSTS_SVH
`define C64_AUDIO_CONSTS_SVH

// One-hot ring length for the 1 MHz tick at 32 MHz
`define CE_1M_LEN 32

// Signed 16-bit clamp limits of the mix channels
`define SAMPLE_MAX 32767
`define SAMPLE_MIN (-32768)

// Amplitude of the cassette click added to both channels
`define CASS_LEVEL 1024

// Left and right
`define NUM_CHANNELS 2

`endif

//--- verilog/audio_pkg.sv
// Audio sample types
// Sample, SID output and mix-sum formats, plus the stereo crossfeed
// modes of the audio output stage
`default_nettype none

package audio_pkg;

	// Final 16-bit signed audio sample, also the OPL2 output format
	typedef logic signed [15:0] sample_t;

	// Raw SID core output
	typedef logic signed [17:0] sid_sample_t;

	// Mix sum with one guard bit above the sample width
	typedef logic signed [16:0] sum_t;

	// Stereo crossfeed, same encoding as the framework AUDIO_MIX field
	typedef enum logic [1:0] {
		MIX_NONE = 2'd0,
		MIX_25   = 2'd1,
		MIX_50   = 2'd2,
		MIX_MONO = 2'd3
	} mix_mode_t;

endpackage

`default_nettype wire

//--- verilog/sidbus_pkg.sv
// SID bus types
// Address placement of the second (right) SID and the SID model
// select used by the I/O decode and the audio source select
`default_nettype none

package sidbus_pkg;

	// Where the right SID answers on the bus
	typedef enum logic [2:0] {
		SID_SAME = 3'd0,
		SID_DE00 = 3'd1,
		SID_D420 = 3'd2,
		SID_D500 = 3'd3,
		SID_DF00 = 3'd4
	} sid_addr_mode_t;

	// Chip model of the right SID
	typedef enum logic {
		SID_6581 = 1'b0,
		SID_8580 = 1'b1
	} sid_model_t;

endpackage

`default_nettype wire

//--- verilog/sid_bus_decode.sv
// Right-SID bus decode
// Generates the 1 MHz SID tick from a rotating one-hot ring, detects
// CPU writes into the IOE and IOF areas, and places the right SID at
// its chosen address for both the write strobe and the read data
`timescale 1ns/10ps
`include "c64_audio_consts.svh"
`default_nettype none

module sid_bus_decode (
	input  wire                         clk_sys,
	input  wire                         reset_n,
	input  wire                         ioe_i,
	input  wire                         iof_i,
	input  wire                         ram_we_n_i,
	input  wire                         sid_we_int_i,
	input  sidbus_pkg::sid_addr_mode_t  sid_addr_mode_i,
	input  sidbus_pkg::sid_model_t      right_sid_model_i,
	input  wire  [7:0]                  sid6581_rdata_i,
	input  wire  [7:0]                  sid8580_rdata_i,
	input  wire  [7:0]                  opl_rdata_i,
	output logic                        ce_1m_o,
	output logic                        sid2_we_o,
	output logic [7:0]                  io_data_o
);

	import sidbus_pkg::*;

	logic [`CE_1M_LEN-1:0] ce_ring;
	logic                  ioe_q;
	logic                  iof_q;
	logic                  ioe_we;
	logic                  iof_we;
	logic                  sid2_oe;

	// Tick ring, one set bit walks up once per clock
	always_ff @(posedge clk_sys) begin
		if (!reset_n) begin
			ce_ring <= `CE_1M_LEN'(1);
		end else begin
			ce_ring <= {ce_ring[`CE_1M_LEN-2:0], ce_ring[`CE_1M_LEN-1]};
		end
	end

	assign ce_1m_o = ce_ring[`CE_1M_LEN-1];

	// Rising edge of an I/O select while the CPU writes
	always_ff @(posedge clk_sys) begin
		if (!reset_n) begin
			ioe_q  <= 1'b0;
			iof_q  <= 1'b0;
			ioe_we <= 1'b0;
			iof_we <= 1'b0;
		end else begin
			ioe_q  <= ioe_i;
			iof_q  <= iof_i;
			ioe_we <= ~ioe_q & ioe_i & ~ram_we_n_i;
			iof_we <= ~iof_q & iof_i & ~ram_we_n_i;
		end
	end

	// SID_SAME, D420 and D500 are already decoded inside the C64
	always_comb begin
		case (sid_addr_mode_i)
			SID_DE00: begin
				sid2_we_o = ioe_we;
				sid2_oe   = ioe_i;
			end
			SID_DF00: begin
				sid2_we_o = iof_we;
				sid2_oe   = iof_i;
			end
			default: begin
				sid2_we_o = sid_we_int_i;
				sid2_oe   = ~ioe_i & ~iof_i;
			end
		endcase
	end

	// OPL2 expander answers whenever the right SID does not
	assign io_data_o = !sid2_oe ? opl_rdata_i :
		(right_sid_model_i == SID_8580) ? sid8580_rdata_i : sid6581_rdata_i;

endmodule

`default_nettype wire

//--- verilog/audio_source_sel.sv
// Audio source select
// Picks the right SID model, scales both SID outputs to the mix width,
// extends the OPL2 sample and forms the cassette click, one register
`timescale 1ns/10ps
`include "c64_audio_consts.svh"
`default_nettype none

module audio_source_sel (
	input  wire                     clk_sys,
	input  wire                     reset_n,
	input  audio_pkg::sample_t      opl_sample_i,
	input  audio_pkg::sid_sample_t  sid_l_sample_i,
	input  audio_pkg::sid_sample_t  sid6581_r_sample_i,
	input  audio_pkg::sid_sample_t  sid8580_r_sample_i,
	input  sidbus_pkg::sid_model_t  right_sid_model_i,
	input  wire                     cass_run_i,
	input  wire                     tape_sound_en_i,
	input  wire                     cass_data_i,
	output audio_pkg::sum_t         sid_term_o [0:1],
	output audio_pkg::sum_t         opl_term_o,
	output audio_pkg::sum_t         cass_term_o
);

	import audio_pkg::*;
	import sidbus_pkg::*;

	sid_sample_t sid_r_sample;
	logic        cass_snd;

	assign sid_r_sample = (right_sid_model_i == SID_8580) ? sid8580_r_sample_i :
		sid6581_r_sample_i;

	// Click only while the motor runs and tape sound is on
	assign cass_snd = cass_run_i & tape_sound_en_i & cass_data_i;

	always_ff @(posedge clk_sys) begin
		if (!reset_n) begin
			sid_term_o[0] <= '0;
			sid_term_o[1] <= '0;
			opl_term_o    <= '0;
			cass_term_o   <= '0;
		end else begin
			// SID output divided by four
			sid_term_o[0] <= sum_t'(sid_l_sample_i >>> 2);
			sid_term_o[1] <= sum_t'(sid_r_sample >>> 2);
			opl_term_o    <= sum_t'(opl_sample_i);
			cass_term_o   <= cass_snd ? sum_t'(`CASS_LEVEL) : '0;
		end
	end

endmodule

`default_nettype wire

//--- verilog/mix_channel.sv
// Mix channel
// Adds the SID, OPL2 and cassette terms of one channel and clamps the
// result to a signed 16-bit sample, two register stages
`timescale 1ns/10ps
`include "c64_audio_consts.svh"
`default_nettype none

module mix_channel (
	input  wire                 clk_sys,
	input  wire                 reset_n,
	input  audio_pkg::sum_t     sid_term_i,
	input  audio_pkg::sum_t     opl_term_i,
	input  audio_pkg::sum_t     cass_term_i,
	output audio_pkg::sample_t  sample_o
);

	import audio_pkg::*;

	sum_t sum_q;

	always_ff @(posedge clk_sys) begin
		if (!reset_n) begin
			sum_q    <= '0;
			sample_o <= '0;
		end else begin
			// 17-bit sum, wraps on extreme inputs like the C64 core
			sum_q <= sid_term_i + opl_term_i + cass_term_i;

			if (sum_q > `SAMPLE_MAX) begin
				sample_o <= sample_t'(`SAMPLE_MAX);
			end else if (sum_q < `SAMPLE_MIN) begin
				sample_o <= sample_t'(`SAMPLE_MIN);
			end else begin
				sample_o <= sample_t'(sum_q);
			end
		end
	end

endmodule

`default_nettype wire

//--- verilog/stereo_crossfeed.sv
// Stereo crossfeed
// Blends some of the opposite channel into each output, from none up
// to full mono, and registers both outputs
`timescale 1ns/10ps
`default_nettype none

module stereo_crossfeed (
	input  wire                   clk_sys,
	input  wire                   reset_n,
	input  audio_pkg::sample_t    left_i,
	input  audio_pkg::sample_t    right_i,
	input  audio_pkg::mix_mode_t  mix_mode_i,
	output audio_pkg::sample_t    audio_l_o,
	output audio_pkg::sample_t    audio_r_o
);

	import audio_pkg::*;

	// =====================================================================
	// Blend of one output from its own and the opposite channel
	// =====================================================================
	// Arithmetic shifts round toward minus infinity; the results stay
	// inside the 16-bit range for every input pair
	function automatic sample_t blend(input sample_t own, input sample_t other,
		input mix_mode_t mode);
		case (mode)
			MIX_25:   blend = own - (own >>> 3) + (other >>> 3);
			MIX_50:   blend = own - (own >>> 2) + (other >>> 2);
			MIX_MONO: blend = (own >>> 1) + (other >>> 1);
			default:  blend = own;
		endcase
	endfunction

	// =====================================================================
	// Output registers
	// =====================================================================
	always_ff @(posedge clk_sys) begin
		if (!reset_n) begin
			audio_l_o <= '0;
			audio_r_o <= '0;
		end else begin
			audio_l_o <= blend(left_i, right_i, mix_mode_i);
			audio_r_o <= blend(right_i, left_i, mix_mode_i);
		end
	end

endmodule

`default_nettype wire

//--- verilog/c64_audio_top.sv
// C64 audio top level
// 1 MHz SID tick, right-SID bus decode, per-channel mix of OPL2, SID
// and cassette sound, and the stereo crossfeed stage
`timescale 1ns/10ps
`include "c64_audio_consts.svh"
`default_nettype none

module c64_audio_top (
	input  wire                         clk_sys,
	input  wire                         reset_n,
	// Audio sources
	input  audio_pkg::sample_t          opl_sample_i,
	input  audio_pkg::sid_sample_t      sid_l_sample_i,
	input  audio_pkg::sid_sample_t      sid6581_r_sample_i,
	input  audio_pkg::sid_sample_t      sid8580_r_sample_i,
	input  sidbus_pkg::sid_model_t      right_sid_model_i,
	input  wire                         cass_run_i,
	input  wire                         tape_sound_en_i,
	input  wire                         cass_data_i,
	input  audio_pkg::mix_mode_t        mix_mode_i,
	// CPU side of the I/O area
	input  wire                         ioe_i,
	input  wire                         iof_i,
	input  wire                         ram_we_n_i,
	input  wire                         sid_we_int_i,
	input  sidbus_pkg::sid_addr_mode_t  sid_addr_mode_i,
	input  wire  [7:0]                  sid6581_rdata_i,
	input  wire  [7:0]                  sid8580_rdata_i,
	input  wire  [7:0]                  opl_rdata_i,
	// Outputs
	output logic                        ce_1m_o,
	output logic                        sid2_we_o,
	output logic [7:0]                  io_data_o,
	output audio_pkg::sample_t          audio_l_o,
	output audio_pkg::sample_t          audio_r_o
);

	import audio_pkg::*;

	sum_t    sid_term [0:`NUM_CHANNELS-1];
	sum_t    opl_term;
	sum_t    cass_term;
	sample_t chan_sample [0:`NUM_CHANNELS-1];

	sid_bus_decode u_decode (
		.clk_sys           (clk_sys),
		.reset_n           (reset_n),
		.ioe_i             (ioe_i),
		.iof_i             (iof_i),
		.ram_we_n_i        (ram_we_n_i),
		.sid_we_int_i      (sid_we_int_i),
		.sid_addr_mode_i   (sid_addr_mode_i),
		.right_sid_model_i (right_sid_model_i),
		.sid6581_rdata_i   (sid6581_rdata_i),
		.sid8580_rdata_i   (sid8580_rdata_i),
		.opl_rdata_i       (opl_rdata_i),
		.ce_1m_o           (ce_1m_o),
		.sid2_we_o         (sid2_we_o),
		.io_data_o         (io_data_o)
	);

	audio_source_sel u_source (
		.clk_sys            (clk_sys),
		.reset_n            (reset_n),
		.opl_sample_i       (opl_sample_i),
		.sid_l_sample_i     (sid_l_sample_i),
		.sid6581_r_sample_i (sid6581_r_sample_i),
		.sid8580_r_sample_i (sid8580_r_sample_i),
		.right_sid_model_i  (right_sid_model_i),
		.cass_run_i         (cass_run_i),
		.tape_sound_en_i    (tape_sound_en_i),
		.cass_data_i        (cass_data_i),
		.sid_term_o         (sid_term),
		.opl_term_o         (opl_term),
		.cass_term_o        (cass_term)
	);

	// Channel 0 is left, channel 1 is right
	for (genvar ch = 0; ch < `NUM_CHANNELS; ch++) begin : g_chan
		mix_channel u_mix (
			.clk_sys     (clk_sys),
			.reset_n     (reset_n),
			.sid_term_i  (sid_term[ch]),
			.opl_term_i  (opl_term),
			.cass_term_i (cass_term),
			.sample_o    (chan_sample[ch])
		);
	end

	stereo_crossfeed u_xfeed (
		.clk_sys    (clk_sys),
		.reset_n    (reset_n),
		.left_i     (chan_sample[0]),
		.right_i    (chan_sample[1]),
		.mix_mode_i (mix_mode_i),
		.audio_l_o  (audio_l_o),
		.audio_r_o  (audio_r_o)
	);

endmodule

`default_nettype wire

//--- sim/c64_audio_chk.sv
// Protocol checks for the C64 audio block
// Tick period, one-cycle I/O write strobes and the state left by reset
`timescale 1ns/10ps
`include "c64_audio_consts.svh"
`default_nettype none

module c64_audio_chk (
	input wire        clk_sys,
	input wire        reset_n,
	input wire        ce_1m_i,
	input wire        ioe_we_i,
	input wire        iof_we_i,
	input wire [15:0] audio_l_i,
	input wire [15:0] audio_r_i
);

	int fail_count = 0;
	int tick_gap;

	// Cycles since the last tick
	always_ff @(posedge clk_sys) begin
		if (!reset_n || ce_1m_i) begin
			tick_gap <= 0;
		end else begin
			tick_gap <= tick_gap + 1;
		end
	end

	// Tick high exactly once per ring turn
	a_tick_period: assert property (@(posedge clk_sys) disable iff (!reset_n)
		ce_1m_i == (tick_gap == `CE_1M_LEN - 1))
	else begin
		fail_count++;
		$error("tick outside its 32-cycle slot");
	end

	a_ioe_strobe: assert property (@(posedge clk_sys) disable iff (!reset_n)
		ioe_we_i |=> !ioe_we_i)
	else begin
		fail_count++;
		$error("IOE write strobe longer than one cycle");
	end

	a_iof_strobe: assert property (@(posedge clk_sys) disable iff (!reset_n)
		iof_we_i |=> !iof_we_i)
	else begin
		fail_count++;
		$error("IOF write strobe longer than one cycle");
	end

	// Registered outputs cleared by a reset edge
	a_reset_state: assert property (@(posedge clk_sys)
		!reset_n |=> (audio_l_i == 16'd0 && audio_r_i == 16'd0 && !ce_1m_i &&
		!ioe_we_i && !iof_we_i))
	else begin
		fail_count++;
		$error("outputs not cleared by reset");
	end

endmodule

`default_nettype wire

//--- sim/c64_audio_tb.sv
// C64 audio testbench
// Drives the audio block with random and corner-case stimulus, predicts
// tick, right-SID decode and audio outputs, and checks them every cycle
`timescale 1ns/10ps
`include "c64_audio_consts.svh"
`default_nettype none

module c64_audio_tb;

	import audio_pkg::*;
	import sidbus_pkg::*;

	localparam int CLK_HALF = 20;
	// Well above the roughly 830 cycles of stimulus
	localparam int TIMEOUT_CYCLES = 3000;

	logic           clk_sys = 1'b0;
	logic           reset_n;
	sample_t        opl_sample_i;
	sid_sample_t    sid_l_sample_i;
	sid_sample_t    sid6581_r_sample_i;
	sid_sample_t    sid8580_r_sample_i;
	sid_model_t     right_sid_model_i;
	logic           cass_run_i;
	logic           tape_sound_en_i;
	logic           cass_data_i;
	mix_mode_t      mix_mode_i;
	logic           ioe_i;
	logic           iof_i;
	logic           ram_we_n_i;
	logic           sid_we_int_i;
	sid_addr_mode_t sid_addr_mode_i;
	logic [7:0]     sid6581_rdata_i;
	logic [7:0]     sid8580_rdata_i;
	logic [7:0]     opl_rdata_i;
	logic           ce_1m_o;
	logic           sid2_we_o;
	logic [7:0]     io_data_o;
	sample_t        audio_l_o;
	sample_t        audio_r_o;

	int   value_errors = 0;
	int   cycle_count = 0;
	int   tick_edges = 0;
	logic ioe_prev = 1'b0;
	logic iof_prev = 1'b0;
	// Expected channel samples with entry 0 for the inputs of this edge
	int   exp_l [0:3] = '{0, 0, 0, 0};
	int   exp_r [0:3] = '{0, 0, 0, 0};

	c64_audio_top dut (.*);

	bind c64_audio_top c64_audio_chk u_chk (
		.clk_sys   (clk_sys),
		.reset_n   (reset_n),
		.ce_1m_i   (ce_1m_o),
		.ioe_we_i  (u_decode.ioe_we),
		.iof_we_i  (u_decode.iof_we),
		.audio_l_i (audio_l_o),
		.audio_r_i (audio_r_o)
	);

	always #CLK_HALF clk_sys = ~clk_sys;

	// ====================================================================
	// Reference rules
	// ====================================================================
	// Division rounding toward minus infinity
	function automatic int floor_div(input int x, input int d);
		int q;
		q = x / d;
		if ((x % d != 0) && (x < 0)) begin
			q = q - 1;
		end
		return q;
	endfunction

	// One channel before the crossfeed with 17-bit wrap and clamp
	function automatic int channel_value(input int sid, input int opl, input bit cass);
		int s;
		s = floor_div(sid, 4) + opl + (cass ? `CASS_LEVEL : 0);
		if (s > 65535) begin
			s = s - 131072;
		end
		if (s > `SAMPLE_MAX) begin
			s = `SAMPLE_MAX;
		end else if (s < `SAMPLE_MIN) begin
			s = `SAMPLE_MIN;
		end
		return s;
	endfunction

	function automatic int crossfeed_value(input int own, input int other, input mix_mode_t mode);
		case (mode)
			MIX_25:   return own - floor_div(own, 8) + floor_div(other, 8);
			MIX_50:   return own - floor_div(own, 4) + floor_div(other, 4);
			MIX_MONO: return floor_div(own, 2) + floor_div(other, 2);
			default:  return own;
		endcase
	endfunction

	task automatic check_equal(input string name, input int expected, input int actual);
		assert (expected == actual) else begin
			value_errors++;
			$display("[ERROR] %s: expected %0d, actual %0d", name, expected, actual);
		end
	endtask

	// ====================================================================
	// Per-cycle output checks 1 ns after the edge
	// ====================================================================
	always @(posedge clk_sys) begin : check_outputs
		logic       rd_en;
		logic       we_exp;
		logic [7:0] rd_exp;
		bit         cass_on;
		#1;
		cass_on = cass_run_i & tape_sound_en_i & cass_data_i;
		for (int i = 3; i > 0; i--) begin
			exp_l[i] = exp_l[i-1];
			exp_r[i] = exp_r[i-1];
		end
		if (reset_n) begin
			exp_l[0] = channel_value(int'(sid_l_sample_i), int'(opl_sample_i), cass_on);
			exp_r[0] = channel_value(right_sid_model_i == SID_8580 ?
				int'(sid8580_r_sample_i) : int'(sid6581_r_sample_i),
				int'(opl_sample_i), cass_on);
			tick_edges++;
		end else begin
			exp_l[0] = 0;
			exp_r[0] = 0;
			tick_edges = 0;
		end
		// Audio of the inputs sampled three edges ago
		check_equal("audio_left", crossfeed_value(exp_l[3], exp_r[3], mix_mode_i),
			int'(audio_l_o));
		check_equal("audio_right", crossfeed_value(exp_r[3], exp_l[3], mix_mode_i),
			int'(audio_r_o));
		if (mix_mode_i == MIX_MONO) begin
			check_equal("mono_equal", crossfeed_value(exp_l[3], exp_r[3], MIX_MONO),
				int'(audio_r_o));
		end
		check_equal("tick", (reset_n && tick_edges % `CE_1M_LEN == `CE_1M_LEN - 1) ? 1 : 0,
			int'(ce_1m_o));

		case (sid_addr_mode_i)
			SID_DE00: begin
				we_exp = reset_n && !ioe_prev && ioe_i && !ram_we_n_i;
				rd_en  = ioe_i;
			end
			SID_DF00: begin
				we_exp = reset_n && !iof_prev && iof_i && !ram_we_n_i;
				rd_en  = iof_i;
			end
			default: begin
				we_exp = sid_we_int_i;
				rd_en  = !ioe_i && !iof_i;
			end
		endcase
		if (!rd_en) begin
			rd_exp = opl_rdata_i;
		end else if (right_sid_model_i == SID_6581) begin
			rd_exp = sid6581_rdata_i;
		end else begin
			rd_exp = sid8580_rdata_i;
		end
		check_equal("sid2_we", int'(we_exp), int'(sid2_we_o));
		check_equal("io_data", int'(rd_exp), int'(io_data_o));
		ioe_prev = reset_n ? ioe_i : 1'b0;
		iof_prev = reset_n ? iof_i : 1'b0;
	end

	// ====================================================================
	// Stimulus
	// ====================================================================
	task automatic next_cycle();
		@(posedge clk_sys);
		#2;
	endtask

	task automatic load_random_samples();
		opl_sample_i       = sample_t'($urandom);
		sid_l_sample_i     = sid_sample_t'($urandom);
		sid6581_r_sample_i = sid_sample_t'($urandom);
		sid8580_r_sample_i = sid_sample_t'($urandom);
	endtask

	initial begin
		while (cycle_count < TIMEOUT_CYCLES) begin
			@(posedge clk_sys);
			cycle_count++;
		end
		$display("Timeout: stimulus still running after %0d cycles", TIMEOUT_CYCLES);
		$display("Verification failed");
		$finish;
	end

	initial begin
		void'($urandom(32'hda6e));
		reset_n            = 1'b0;
		opl_sample_i       = '0;
		sid_l_sample_i     = '0;
		sid6581_r_sample_i = '0;
		sid8580_r_sample_i = '0;
		right_sid_model_i  = SID_6581;
		cass_run_i         = 1'b0;
		tape_sound_en_i    = 1'b0;
		cass_data_i        = 1'b0;
		mix_mode_i         = MIX_NONE;
		ioe_i              = 1'b0;
		iof_i              = 1'b0;
		ram_we_n_i         = 1'b1;
		sid_we_int_i       = 1'b0;
		sid_addr_mode_i    = SID_SAME;
		sid6581_rdata_i    = '0;
		sid8580_rdata_i    = '0;
		opl_rdata_i        = '0;
		repeat (2) @(posedge clk_sys);
		#2;
		reset_n = 1'b1;

		// Two idle tick periods
		repeat (70) next_cycle();

		// Random mix without crossfeed
		repeat (200) begin
			next_cycle();
			load_random_samples();
			right_sid_model_i = sid_model_t'($urandom_range(0, 1));
		end

		// Full-scale corners including the 17-bit wrap
		for (int c = 0; c < 16; c++) begin
			next_cycle();
			sid_l_sample_i     = c[0] ? 18'sh1ffff : 18'sh20000;
			sid6581_r_sample_i = c[1] ? 18'sh1ffff : 18'sh20000;
			sid8580_r_sample_i = c[1] ? 18'sh20000 : 18'sh1ffff;
			opl_sample_i       = c[2] ? 16'sh7fff : 16'sh8000;
			right_sid_model_i  = sid_model_t'(c[0]);
			cass_run_i         = c[3];
			tape_sound_en_i    = c[3];
			cass_data_i        = c[3];
		end

		// Every cassette enable combination
		for (int c = 0; c < 8; c++) begin
			repeat (4) begin
				next_cycle();
				load_random_samples();
				cass_run_i      = c[0];
				tape_sound_en_i = c[1];
				cass_data_i     = c[2];
			end
		end

		// Right SID model select
		for (int m = 0; m < 2; m++) begin
			repeat (30) begin
				next_cycle();
				load_random_samples();
				right_sid_model_i = sid_model_t'(m);
			end
		end

		// Crossfeed modes
		for (int m = 0; m < 4; m++) begin
			repeat (60) begin
				next_cycle();
				load_random_samples();
				mix_mode_i  = mix_mode_t'(m);
				cass_data_i = 1'($urandom_range(0, 1));
			end
		end

		// Random bus traffic in every right-SID address mode
		for (int m = 0; m < 5; m++) begin
			repeat (40) begin
				next_cycle();
				sid_addr_mode_i   = sid_addr_mode_t'(m);
				ioe_i             = 1'($urandom_range(0, 1));
				iof_i             = 1'($urandom_range(0, 1));
				ram_we_n_i        = 1'($urandom_range(0, 1));
				sid_we_int_i      = 1'($urandom_range(0, 1));
				right_sid_model_i = sid_model_t'($urandom_range(0, 1));
				sid6581_rdata_i   = 8'($urandom);
				sid8580_rdata_i   = 8'($urandom);
				opl_rdata_i       = 8'($urandom);
			end
		end

		repeat (6) next_cycle();
		$display("Checks done: %0d value errors, %0d assertion failures",
			value_errors, dut.u_chk.fail_count);
		if (value_errors == 0 && dut.u_chk.fail_count == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- c64_audio_top.f
+incdir+verilog
verilog/audio_pkg.sv
verilog/sidbus_pkg.sv
verilog/sid_bus_decode.sv
verilog/audio_source_sel.sv
verilog/mix_channel.sv
verilog/stereo_crossfeed.sv
verilog/c64_audio_top.sv
sim/c64_audio_chk.sv
sim/c64_audio_tb.sv

//--- Makefile
# Verilator build and run of the C64 audio testbench

VERILATOR ?= verilator
TOP       ?= c64_audio_tb
FILELIST  ?= c64_audio_top.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
RUN_ARGS  ?= +verilator+error+limit+1000
PASS_MSG  ?= Verification passed

SIM_BIN := $(BUILD_DIR)/V$(TOP)
SOURCES := $(wildcard verilog/*.sv verilog/*.svh sim/*.sv)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) $(RUN_ARGS) 2>&1 | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || { echo "Simulation failed, see $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)
